// ==== Bender.yml ====
package:
  name: master_trig

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mtrig_pkg.sv
      - hdl/trig_word_capture.sv
      - hdl/trig_level_two.sv
      - hdl/trig_record_fifo.sv
      - hdl/photo_prescaler.sv
      - hdl/master_trig_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/master_trig_assert.sv
      - verif/master_trig_tb.sv

// ==== build.f ====
+incdir+hdl
hdl/mtrig_pkg.sv
hdl/trig_word_capture.sv
hdl/trig_level_two.sv
hdl/trig_record_fifo.sv
hdl/photo_prescaler.sv
hdl/master_trig_top.sv
verif/master_trig_assert.sv
verif/master_trig_tb.sv

// ==== hdl/master_trig_top.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module master_trig_top (
    input  logic                                     sysclk_i,
    input  logic                                     runrst_i,
    input  logic                                     runstop_i,
    // SURF trigger words and their valid bits
    input  mtrig_pkg::trig_word_u [`MTRIG_NCHAN-1:0] trigin_word_i,
    input  logic [`MTRIG_NCHAN-1:0]                  trigin_valid_i,
    // run configuration, sampled at runrst_i
    input  logic [`MTRIG_NCHAN-1:0]                  trig_mask_i,
    input  logic [`MTRIG_ADDRBITS-1:0]               trig_offset_i,
    input  logic [15:0]                              trig_holdoff_i,
    input  logic [15:0]                              photo_prescale_i,
    input  logic                                     photo_en_i,
    // record stream
    output mtrig_pkg::trig_rec_t                     trigout_data_o,
    output logic                                     trigout_valid_o,
    input  logic                                     trigout_ready_i,
    // status
    output logic                                     holdoff_o,
    output logic                                     running_o,
    output logic [`MTRIG_ADDRBITS-1:0]               address_o,
    output logic [`MTRIG_NCHAN-1:0]                  scal_trig_o,
    output logic                                     photoshutter_o,
    output logic                                     overflow_o
);

    // decoded channel messages
    mtrig_pkg::chan_hit_t [`MTRIG_NCHAN-1:0] hits;
    // level-two record and its strobe
    mtrig_pkg::trig_rec_t rec;
    logic rec_push;

    // one decoder per SURF channel
    for (genvar c = 0; c < `MTRIG_NCHAN; c++) begin : g_chan
        trig_word_capture u_capture (
            .sysclk_i     (sysclk_i),
            .runrst_i     (runrst_i),
            .word_i       (trigin_word_i[c]),
            .word_valid_i (trigin_valid_i[c]),
            .hit_o        (hits[c])
        );
        // scalers see raw hits, before the mask
        assign scal_trig_o[c] = hits[c].hit;
    end

    trig_level_two u_level_two (
        .sysclk_i   (sysclk_i),
        .runrst_i   (runrst_i),
        .runstop_i  (runstop_i),
        .hits_i     (hits),
        .trig_mask_i(trig_mask_i),
        .offset_i   (trig_offset_i),
        .holdoff_i  (trig_holdoff_i),
        .rec_o      (rec),
        .rec_push_o (rec_push),
        .holdoff_o  (holdoff_o),
        .running_o  (running_o),
        .address_o  (address_o)
    );

    trig_record_fifo u_fifo (
        .sysclk_i        (sysclk_i),
        .runrst_i        (runrst_i),
        .rec_i           (rec),
        .push_i          (rec_push),
        .trigout_data_o  (trigout_data_o),
        .trigout_valid_o (trigout_valid_o),
        .trigout_ready_i (trigout_ready_i),
        .overflow_o      (overflow_o)
    );

    // counts the same strobe that pushes records
    photo_prescaler u_photo (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .trig_i         (rec_push),
        .prescale_i     (photo_prescale_i),
        .photo_en_i     (photo_en_i),
        .photoshutter_o (photoshutter_o)
    );

endmodule

// ==== hdl/mtrig_params.svh ====
`ifndef MTRIG_PARAMS_SVH
`define MTRIG_PARAMS_SVH

// number of SURF trigger channels
`define MTRIG_NCHAN 4

// trigger address width
// one address per sample window, wraps modulo 4096
`define MTRIG_ADDRBITS 12

// record FIFO depth
// must be a power of two for the pointer wrap bit
`define MTRIG_FIFO_DEPTH 8

// tag on the top two bits of every outbound trigger word
// lets the receiver tell a trigger word apart from idle fill
`define MTRIG_MARKER 2'b10

`endif

// ==== hdl/mtrig_pkg.sv ====
`include "mtrig_params.svh"

package mtrig_pkg;

    // first word of a message, carries the trigger address
    // bottom two bits are spare and always skipped
    typedef struct packed {
        logic                       flag;
        logic                       rsvd_hi;
        logic [`MTRIG_ADDRBITS-1:0] addr;
        logic [1:0]                 rsvd_lo;
    } trig_addr_view_t;

    // second word of a message, carries the metadata byte
    typedef struct packed {
        logic       flag;
        logic [6:0] rsvd;
        logic [7:0] meta;
    } trig_meta_view_t;

    // one 16-bit trigger word, decoded by message position
    typedef union packed {
        trig_addr_view_t addr_w;
        trig_meta_view_t meta_w;
    } trig_word_u;

    // decoded message for one channel
    typedef struct packed {
        logic                       hit;
        logic [`MTRIG_ADDRBITS-1:0] addr;
        logic [7:0]                 meta;
    } chan_hit_t;

    // one level-two trigger record
    // word is marker, offset address, two zero bits
    typedef struct packed {
        logic [15:0]             word;
        logic [`MTRIG_NCHAN-1:0] hits;
        logic [7:0]              meta;
    } trig_rec_t;

endpackage

// ==== hdl/photo_prescaler.sv ====
`timescale 1ns/1ns

module photo_prescaler (
    input  logic        sysclk_i,
    input  logic        runrst_i,
    input  logic        trig_i,
    input  logic [15:0] prescale_i,
    input  logic        photo_en_i,
    output logic        photoshutter_o
);

    // settings captured at run start
    logic [15:0] prescale_q;
    logic        photo_en_q;

    // down counter, bit 16 marks the Nth trigger
    logic [16:0] cnt_q;
    logic        shutter_q;
    logic        active;

    // zero prescale means no pulses at all
    assign active = photo_en_q && (prescale_q != 16'd0);

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            prescale_q <= prescale_i;
            photo_en_q <= photo_en_i;
        end
    end

    // count N-1 down to underflow, then reload
    // pulse lands the cycle after holdoff rises for the Nth trigger
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            cnt_q     <= {1'b0, prescale_i - 16'd1};
            shutter_q <= 1'b0;
        end else begin
            shutter_q <= cnt_q[16];
            if (cnt_q[16]) begin
                cnt_q <= {1'b0, prescale_q - 16'd1};
            end else if (active && trig_i) begin
                cnt_q <= cnt_q - 17'd1;
            end
        end
    end

    assign photoshutter_o = shutter_q;

endmodule

// ==== hdl/trig_level_two.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module trig_level_two (
    input  logic                                          sysclk_i,
    input  logic                                          runrst_i,
    input  logic                                          runstop_i,
    input  mtrig_pkg::chan_hit_t [`MTRIG_NCHAN-1:0]       hits_i,
    input  logic [`MTRIG_NCHAN-1:0]                       trig_mask_i,
    input  logic [`MTRIG_ADDRBITS-1:0]                    offset_i,
    input  logic [15:0]                                   holdoff_i,
    output mtrig_pkg::trig_rec_t                          rec_o,
    output logic                                          rec_push_o,
    output logic                                          holdoff_o,
    output logic                                          running_o,
    output logic [`MTRIG_ADDRBITS-1:0]                    address_o
);

    // run configuration, sampled while runrst_i is high
    logic [`MTRIG_NCHAN-1:0]    mask_q;
    logic [`MTRIG_ADDRBITS-1:0] offset_q;
    logic [15:0]                holdoff_val_q;

    // control state
    logic                       running_q;
    logic [`MTRIG_ADDRBITS-1:0] cur_addr_q;
    logic                       push_q;
    logic                       holdoff_q;
    logic [15:0]                hold_cnt_q;

    // record payload
    mtrig_pkg::trig_rec_t       rec_q;

    // masked hits and selected metadata
    logic [`MTRIG_NCHAN-1:0]    acc_hits;
    logic [7:0]                 sel_meta;
    logic                       fire;

    // mask the hits, lowest hit channel wins the metadata
    always_comb begin
        acc_hits = '0;
        sel_meta = '0;
        for (int c = `MTRIG_NCHAN - 1; c >= 0; c--) begin
            acc_hits[c] = hits_i[c].hit && !mask_q[c];
            if (acc_hits[c]) begin
                sel_meta = hits_i[c].meta;
            end
        end
    end

    // trigger cycle itself counts as dead, holdoff starts right after it
    assign fire = (|acc_hits) && running_q && !holdoff_q && !push_q;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            mask_q        <= trig_mask_i;
            offset_q      <= offset_i;
            holdoff_val_q <= holdoff_i;
        end
    end

    // run flag, current address, trigger strobe and holdoff
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            running_q  <= 1'b1;
            cur_addr_q <= '0;
            push_q     <= 1'b0;
            holdoff_q  <= 1'b0;
            hold_cnt_q <= '0;
        end else begin
            if (runstop_i) begin
                running_q <= 1'b0;
            end
            // address advances every running cycle
            if (running_q) begin
                cur_addr_q <= cur_addr_q + 1'b1;
            end
            push_q <= fire;
            // load on the trigger edge, high for hold_cnt_q cycles
            if (push_q) begin
                holdoff_q  <= 1'b1;
                hold_cnt_q <= holdoff_val_q;
            end else if (holdoff_q) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
                // a zero setting behaves like one
                if (hold_cnt_q <= 16'd1) begin
                    holdoff_q <= 1'b0;
                end
            end
        end
    end

    // record formed on the same edge as the strobe
    // address is taken at the hit cycle, then pulled back by the offset
    always_ff @(posedge sysclk_i) begin
        if (fire) begin
            rec_q.word <= {`MTRIG_MARKER, cur_addr_q - offset_q, 2'b00};
            rec_q.hits <= acc_hits;
            rec_q.meta <= sel_meta;
        end
    end

    assign rec_o      = rec_q;
    assign rec_push_o = push_q;
    assign holdoff_o  = holdoff_q;
    assign running_o  = running_q;
    assign address_o  = cur_addr_q;

endmodule

// ==== hdl/trig_record_fifo.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module trig_record_fifo (
    input  logic                  sysclk_i,
    input  logic                  runrst_i,
    input  mtrig_pkg::trig_rec_t  rec_i,
    input  logic                  push_i,
    output mtrig_pkg::trig_rec_t  trigout_data_o,
    output logic                  trigout_valid_o,
    input  logic                  trigout_ready_i,
    output logic                  overflow_o
);

    localparam int DEPTH = `MTRIG_FIFO_DEPTH;
    localparam int PTRW  = $clog2(DEPTH);

    // record storage
    mtrig_pkg::trig_rec_t mem_q [DEPTH];

    // pointers carry one wrap bit above the index
    logic [PTRW:0] wr_ptr_q;
    logic [PTRW:0] rd_ptr_q;
    logic          overflow_q;

    logic empty;
    logic full;
    logic do_push;
    logic do_pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    // same index, opposite wrap bits
    assign full = (wr_ptr_q[PTRW] != rd_ptr_q[PTRW])
               && (wr_ptr_q[PTRW-1:0] == rd_ptr_q[PTRW-1:0]);

    // push into a full FIFO is lost
    assign do_push = push_i && !full;
    // transfer on valid and ready
    assign do_pop = !empty && trigout_ready_i;

    always_ff @(posedge sysclk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q[PTRW-1:0]] <= rec_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // sticky until the next run
            if (push_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    // head record stays put until it is taken
    assign trigout_data_o  = mem_q[rd_ptr_q[PTRW-1:0]];
    assign trigout_valid_o = !empty;
    assign overflow_o      = overflow_q;

endmodule

// ==== hdl/trig_word_capture.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module trig_word_capture (
    input  logic                   sysclk_i,
    input  logic                   runrst_i,
    input  mtrig_pkg::trig_word_u  word_i,
    input  logic                   word_valid_i,
    output mtrig_pkg::chan_hit_t   hit_o
);

    // high between the address word and the metadata word
    logic waiting_q;
    // one-cycle hit strobe
    logic hit_q;
    // payload held across the message
    logic [`MTRIG_ADDRBITS-1:0] addr_q;
    logic [7:0] meta_q;

    // accept conditions for each half of the message
    logic take_addr;
    logic take_meta;

    // address word must carry the flag, anything else in idle is noise
    assign take_addr = word_valid_i && !waiting_q && word_i.addr_w.flag;
    // metadata word is the next valid word, flag not checked
    assign take_meta = word_valid_i && waiting_q;

    // message state and hit strobe
    // runs whether or not a run is active so the scalers keep counting
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            waiting_q <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            // strobe lasts a single cycle
            hit_q <= take_meta;
            if (take_addr) begin
                waiting_q <= 1'b1;
            end else if (take_meta) begin
                waiting_q <= 1'b0;
            end
        end
    end

    // address from the first word
    always_ff @(posedge sysclk_i) begin
        if (take_addr) begin
            addr_q <= word_i.addr_w.addr;
        end
    end

    // metadata from the second word
    // held with the address until the next message
    always_ff @(posedge sysclk_i) begin
        if (take_meta) begin
            meta_q <= word_i.meta_w.meta;
        end
    end

    assign hit_o.hit  = hit_q;
    assign hit_o.addr = addr_q;
    assign hit_o.meta = meta_q;

endmodule

// ==== verif/master_trig_assert.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module master_trig_assert (
    input logic                       sysclk_i,
    input logic                       runrst_i,
    input logic [`MTRIG_NCHAN-1:0]    trig_mask_i,
    input logic [15:0]                trig_holdoff_i,
    input logic [15:0]                photo_prescale_i,
    input logic                       photo_en_i,
    input mtrig_pkg::trig_rec_t       trigout_data_o,
    input logic                       trigout_valid_o,
    input logic                       trigout_ready_i,
    input logic                       holdoff_o,
    input logic                       running_o,
    input logic [`MTRIG_NCHAN-1:0]    scal_trig_o,
    input logic                       photoshutter_o,
    input logic                       overflow_o
);

    // failed assertions, read back by the testbench
    int fail_cnt = 0;

    // run settings as the DUT captures them
    logic [`MTRIG_NCHAN-1:0] mask_q;
    logic [15:0] hold_set_q;
    logic [15:0] scale_q;
    logic        en_q;
    // holdoff tracking
    logic        hold_d_q;
    logic [15:0] hold_len_q;
    logic [15:0] rise_cnt_q;
    // expected shutter pulse, one cycle after the Nth rise
    logic        shot_exp_q;
    logic        hold_rise;

    assign hold_rise = holdoff_o && !hold_d_q;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            mask_q     <= trig_mask_i;
            hold_set_q <= trig_holdoff_i;
            scale_q    <= photo_prescale_i;
            en_q       <= photo_en_i;
            hold_d_q   <= 1'b0;
            hold_len_q <= '0;
            rise_cnt_q <= '0;
            shot_exp_q <= 1'b0;
        end else begin
            hold_d_q   <= holdoff_o;
            // length of the current window so far
            hold_len_q <= holdoff_o ? hold_len_q + 16'd1 : 16'd0;
            shot_exp_q <= hold_rise && en_q && (scale_q != 16'd0)
                          && (rise_cnt_q == scale_q - 16'd1);
            if (hold_rise) begin
                rise_cnt_q <= (rise_cnt_q == scale_q - 16'd1) ? 16'd0 : rise_cnt_q + 16'd1;
            end
        end
    end

    marker_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        trigout_valid_o |-> (trigout_data_o.word[15:14] == `MTRIG_MARKER)
                            && (trigout_data_o.word[1:0] == 2'b00))
    else begin
        $error("FAILED t=%0t trigout_data_o.word got %h expected %h", $time,
               $sampled(trigout_data_o.word),
               {`MTRIG_MARKER, $sampled(trigout_data_o.word[13:2]), 2'b00});
        fail_cnt++;
    end

    mask_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        trigout_valid_o |-> (trigout_data_o.hits & mask_q) == '0)
    else begin
        $error("FAILED t=%0t trigout_data_o.hits got %b expected %b", $time,
               $sampled(trigout_data_o.hits), $sampled(trigout_data_o.hits) & ~mask_q);
        fail_cnt++;
    end

    // stalled head record must not move
    stall_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        trigout_valid_o && !trigout_ready_i |=> trigout_valid_o && $stable(trigout_data_o))
    else begin
        $error("trigout changed while stalled");
        fail_cnt++;
    end

    window_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        $fell(holdoff_o) |-> hold_len_q == hold_set_q)
    else begin
        $error("FAILED t=%0t holdoff_o window got %0d cycles expected %0d", $time,
               $sampled(hold_len_q), hold_set_q);
        fail_cnt++;
    end

    // hit strobes are single cycles
    pulse_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        (scal_trig_o & $past(scal_trig_o)) == '0)
    else begin
        $error("scaler hit longer than one cycle");
        fail_cnt++;
    end

    shutter_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        photoshutter_o == shot_exp_q)
    else begin
        $error("FAILED t=%0t photoshutter_o got %b expected %b", $time,
               $sampled(photoshutter_o), $sampled(shot_exp_q));
        fail_cnt++;
    end

    overflow_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        !overflow_o)
    else begin
        $error("FAILED t=%0t overflow_o got %b expected 0", $time, $sampled(overflow_o));
        fail_cnt++;
    end

    // a trigger already in flight may still open one window
    stop_check: assert property (@(posedge sysclk_i) disable iff (runrst_i)
        !running_o && !$past(running_o, 2) |-> !$rose(holdoff_o))
    else begin
        $error("holdoff rose after runstop");
        fail_cnt++;
    end

endmodule

// ==== verif/master_trig_tb.sv ====
`timescale 1ns/1ns
`include "mtrig_params.svh"

module master_trig_tb;

    // channel 2 masked for the whole run
    localparam logic [`MTRIG_NCHAN-1:0] MASK = 4'b0100;
    localparam logic [`MTRIG_ADDRBITS-1:0] OFFSET = 12'd5;
    localparam int HOLD = 6;
    localparam int PRESCALE = 3;
    // cycle budget, worst case message is 5 cycles
    localparam int MSG_CYC = 5;
    localparam int DRAIN_CYC = 200;
    localparam int RUN_CYC = 3 + 4 * (MSG_CYC + HOLD + 8) + 12 * (2 * MSG_CYC + HOLD + 17)
                           + 24 * (MSG_CYC + 3) + 8 + 4 * (MSG_CYC + HOLD + 4)
                           + 4 * (DRAIN_CYC + 2) + 100;

    logic sysclk_i = 1'b0;
    logic runrst_i;
    logic runstop_i;
    logic trigout_ready_i;
    mtrig_pkg::trig_word_u [`MTRIG_NCHAN-1:0] trigin_word_i;
    logic [`MTRIG_NCHAN-1:0] trigin_valid_i;
    mtrig_pkg::trig_rec_t trigout_data_o;
    logic trigout_valid_o;
    logic holdoff_o;
    logic running_o;
    logic photoshutter_o;
    logic overflow_o;
    logic [`MTRIG_ADDRBITS-1:0] address_o;
    logic [`MTRIG_NCHAN-1:0] scal_trig_o;

    // last metadata byte sent per channel
    logic [7:0] sent_meta [`MTRIG_NCHAN];
    mtrig_pkg::trig_rec_t exp_q [$];
    int unsigned cyc;
    // expected run flag
    logic run_exp;
    // metadata word on the bus this cycle
    logic meta_now;
    // hits the decoders should show this cycle
    logic [`MTRIG_NCHAN-1:0] hit_exp;
    logic accepted_d;
    int errs = 0;
    int tests = 0;
    int prev_fails = 0;

    always #20 sysclk_i = ~sysclk_i;

    master_trig_top dut_i (
        .sysclk_i (sysclk_i), .runrst_i (runrst_i), .runstop_i (runstop_i),
        .trigin_word_i (trigin_word_i), .trigin_valid_i (trigin_valid_i),
        .trig_mask_i (MASK), .trig_offset_i (OFFSET), .trig_holdoff_i (16'(HOLD)),
        .photo_prescale_i (16'(PRESCALE)), .photo_en_i (1'b1),
        .trigout_data_o (trigout_data_o), .trigout_valid_o (trigout_valid_o),
        .trigout_ready_i (trigout_ready_i), .holdoff_o (holdoff_o), .running_o (running_o),
        .address_o (address_o), .scal_trig_o (scal_trig_o),
        .photoshutter_o (photoshutter_o), .overflow_o (overflow_o)
    );

    bind master_trig_top master_trig_assert u_assert (.*);

    // address counts every running cycle, runstop ends the run
    // hits follow the edge that takes a metadata word
    always @(posedge sysclk_i) begin
        if (runrst_i) begin
            cyc     <= 0;
            run_exp <= 1'b1;
            hit_exp <= '0;
        end else begin
            if (run_exp) begin
                cyc <= cyc + 1;
            end
            if (runstop_i) begin
                run_exp <= 1'b0;
            end
            hit_exp <= meta_now ? trigin_valid_i : '0;
        end
    end

    function automatic int lowest_chan(input logic [`MTRIG_NCHAN-1:0] v);
        for (int c = 0; c < `MTRIG_NCHAN; c++) begin
            if (v[c]) begin
                return c;
            end
        end
        return 0;
    endfunction

    // expected records and transfer check, mid-cycle
    always @(negedge sysclk_i) begin : ref_model
        logic [`MTRIG_NCHAN-1:0] live;
        mtrig_pkg::trig_rec_t exp_rec;
        live = hit_exp & ~MASK;
        if (runrst_i) begin
            accepted_d = 1'b0;
        end else begin
            if (scal_trig_o != hit_exp) begin
                $display("FAILED t=%0t scal_trig_o got %b expected %b",
                         $time, scal_trig_o, hit_exp);
                errs++;
            end
            if (running_o != run_exp) begin
                $display("FAILED t=%0t running_o got %b expected %b",
                         $time, running_o, run_exp);
                errs++;
            end
            if (address_o != cyc[`MTRIG_ADDRBITS-1:0]) begin
                $display("FAILED t=%0t address_o got %0d expected %0d",
                         $time, address_o, cyc[`MTRIG_ADDRBITS-1:0]);
                errs++;
            end
            // the trigger cycle blocks the next one, then holdoff takes over
            if ((|live) && run_exp && !holdoff_o && !accepted_d) begin
                exp_rec.word = {`MTRIG_MARKER, cyc[11:0] - OFFSET, 2'b00};
                exp_rec.hits = live;
                exp_rec.meta = sent_meta[lowest_chan(live)];
                exp_q.push_back(exp_rec);
                accepted_d = 1'b1;
            end else begin
                accepted_d = 1'b0;
            end
            if (trigout_valid_o && trigout_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("record %h left the DUT with no trigger behind it at %0t",
                             trigout_data_o, $time);
                    errs++;
                end else begin
                    exp_rec = exp_q.pop_front();
                    assert (trigout_data_o == exp_rec) else begin
                        $display("FAILED t=%0t trigout_data_o got %h expected %h",
                                 $time, trigout_data_o, exp_rec);
                        errs++;
                    end
                end
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge sysclk_i);
        #2;
    endtask

    // one word on the selected channels for one cycle
    // metadata words get a fresh byte per channel
    task automatic drive_word(input logic [`MTRIG_NCHAN-1:0] sel, input logic [15:0] word,
                              input bit meta);
        for (int c = 0; c < `MTRIG_NCHAN; c++) begin
            trigin_word_i[c] = word;
            if (meta && sel[c]) begin
                sent_meta[c] = 8'($urandom);
                trigin_word_i[c].meta_w.meta = sent_meta[c];
            end
        end
        trigin_valid_i = sel;
        meta_now = meta;
        idle(1);
        trigin_valid_i = '0;
        meta_now = 1'b0;
    endtask

    // flagless noise, address word, random gap, metadata word
    task automatic send_msg(input logic [`MTRIG_NCHAN-1:0] sel);
        drive_word(sel, {1'b0, 15'($urandom)}, 1'b0);
        drive_word(sel, {1'b1, 1'b0, 12'($urandom), 2'b00}, 1'b0);
        idle($urandom % 3);
        drive_word(sel, 16'h0000, 1'b1);
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge sysclk_i);
            #2;
            trigout_ready_i = ($urandom % 3) != 0;
        end
    endtask

    // bounded wait for every expected record to leave
    task automatic drain(input string name);
        int waited;
        waited = 0;
        idle(2);
        while ((exp_q.size() != 0 || trigout_valid_o) && waited < DRAIN_CYC) begin
            idle(1);
            waited++;
        end
        if (exp_q.size() != 0 || trigout_valid_o) begin
            $display("%s: records still pending after %0d cycles", name, DRAIN_CYC);
            errs++;
        end
    endtask

    task automatic finish_test(input string name);
        int now_fails;
        now_fails = errs + dut_i.u_assert.fail_cnt;
        tests++;
        $display("test %0d %s finished, %0d failing checks", tests, name, now_fails - prev_fails);
        prev_fails = now_fails;
    endtask

    initial begin
        void'($urandom(32'h0af9_0559));
        runrst_i = 1'b1;
        runstop_i = 1'b0;
        trigout_ready_i = 1'b0;
        trigin_word_i = '0;
        trigin_valid_i = '0;
        meta_now = 1'b0;
        fork
            drive_ready();
        join_none
        idle(3);
        runrst_i = 1'b0;

        // each channel alone, spaced past holdoff
        for (int c = 0; c < `MTRIG_NCHAN; c++) begin
            send_msg(4'b0001 << c);
            idle(HOLD + 8);
        end
        drain("decode");
        finish_test("decode");

        // second message often lands inside the window
        repeat (12) begin
            send_msg(4'b0001 << ($urandom % 2));
            idle($urandom % 10);
            send_msg(4'b1010);
            idle(HOLD + 8);
        end
        drain("holdoff");
        finish_test("holdoff");

        // dense mixed traffic under random back-pressure
        repeat (24) begin
            send_msg(4'($urandom % 15) + 4'd1);
            idle($urandom % 4);
        end
        drain("flow");
        finish_test("flow");

        runstop_i = 1'b1;
        idle(1);
        runstop_i = 1'b0;
        idle(3);
        assert (running_o == 1'b0) else begin
            $display("FAILED t=%0t running_o got %b expected 0", $time, running_o);
            errs++;
        end
        // hits still decode but start nothing
        repeat (4) begin
            send_msg(4'b0011);
            idle(HOLD + 4);
        end
        drain("runstop");
        finish_test("runstop");

        $display("%0d tests run, %0d failing checks", tests, prev_fails);
        if (prev_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(RUN_CYC * 40);
        $display("watchdog: run did not end within %0d cycles", RUN_CYC);
        $display("** FAIL **");
        $finish;
    end

endmodule
